/* Bender.yml */
package:
  name: board_glue

sources:
  - include_dirs:
      - hw
    files:
      - hw/board_pkg.sv
      - hw/board_reset.sv
      - hw/board_inputs.sv
      - hw/board_dip.sv
      - hw/board_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/board_assertions.sv
      - dv/board_tb.sv

/* dv/board_assertions.sv */
// board_assertions: concurrent reset and pause properties, bound into board_top
`timescale 1ns/1ps
`default_nettype none

module board_assertions (
    input logic clk_sys,
    input logic sys_rst,
    input logic sys_rst_n,
    input logic game_rst,
    input logic game_rst_n,
    input logic downloading,
    input logic soft_rst,
    input logic game_pause
);

    int fail_count = 0;   // failed properties so far

    a_sys_to_game: assert property (@(posedge clk_sys) sys_rst |=> game_rst)
        else begin
            fail_count++;
            $error("game reset not raised after system reset");
        end

    a_game_rst_n: assert property (@(posedge clk_sys) game_rst |=> !game_rst_n)
        else begin
            fail_count++;
            $error("game_rst_n not low after game reset");
        end

    a_dl_sys_n: assert property (@(posedge clk_sys) downloading |=> !sys_rst_n)
        else begin
            fail_count++;
            $error("sys_rst_n not low while downloading");
        end

    a_soft_rst: assert property (@(posedge clk_sys) soft_rst |=> game_rst)
        else begin
            fail_count++;
            $error("soft reset did not restart the game");
        end

    // pause is cleared by the system reset
    a_pause_rst: assert property (@(posedge clk_sys) sys_rst |=> !game_pause)
        else begin
            fail_count++;
            $error("game pause left set during system reset");
        end

endmodule

bind board_top board_assertions u_assertions (
    .clk_sys     ( clk_sys     ),
    .sys_rst     ( sys_rst     ),
    .sys_rst_n   ( sys_rst_n   ),
    .game_rst    ( game_rst    ),
    .game_rst_n  ( game_rst_n  ),
    .downloading ( downloading ),
    .soft_rst    ( soft_rst    ),
    .game_pause  ( game_pause  )
);

`default_nettype wire

/* dv/board_tb.sv */
// board_tb: table-driven testbench with clock, watchdog, check task, reset and trigger tests
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module board_tb;

    import board_pkg::*;

    localparam int NUM_ROWS        = 15;
    localparam int HOLD_EDGES      = 3;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * HOLD_EDGES + 200;
    localparam logic INV           = 1'(`BOARD_INPUTS_ACTIVE_LOW);

    typedef struct packed {
        logic [31:0] status;
        key_map_t    keys;
        pads_t       pads;
        game_ctrl_t  exp_ctrl;
        dip_cfg_t    exp_dip;
        logic [3:0]  exp_gfx;
    } row_t;

    logic        clk_sys;
    logic        rst;
    logic        rst_req;
    logic        downloading;
    logic [31:0] status;
    key_map_t    keys;
    pads_t       pads;
    logic        sys_rst;
    logic        sys_rst_n;
    logic        game_rst;
    logic        game_rst_n;
    game_ctrl_t  game_ctrl;
    logic [3:0]  gfx_en;
    dip_cfg_t    dip_cfg;

    row_t tbl [NUM_ROWS];
    int   errors = 0;
    int   checks = 0;

    board_top u_board_top (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .status      ( status      ),
        .keys        ( keys        ),
        .pads        ( pads        ),
        .sys_rst     ( sys_rst     ),
        .sys_rst_n   ( sys_rst_n   ),
        .game_rst    ( game_rst    ),
        .game_rst_n  ( game_rst_n  ),
        .game_ctrl   ( game_ctrl   ),
        .gfx_en      ( gfx_en      ),
        .dip_cfg     ( dip_cfg     )
    );

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;   // 4 ns period
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("watchdog expired, the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // directions turn a quarter, buttons stay, then polarity
    function automatic game_joy_t expect_joy(input game_joy_t j, input logic rot);
        game_joy_t r;
        r = j;
        if (rot) begin
            r.dirs[3] = j.dirs[0];
            r.dirs[2] = j.dirs[1];
            r.dirs[1] = j.dirs[3];
            r.dirs[0] = j.dirs[2];
        end
        return r ^ {`BOARD_JOY_W{INV}};
    endfunction

    function automatic game_ctrl_t expect_ctrl(input key_map_t k, input pads_t p, input logic rot);
        game_ctrl_t c;
        c.joystick1 = expect_joy(p[0][`BOARD_JOY_W-1:0] | k.joy1, rot);
        c.joystick2 = expect_joy(p[1][`BOARD_JOY_W-1:0] | k.joy2, rot);
        c.joystick3 = expect_joy(p[2][`BOARD_JOY_W-1:0], 1'b0);   // never rotated
        c.joystick4 = expect_joy(p[3][`BOARD_JOY_W-1:0], 1'b0);
        for (int n = 0; n < `BOARD_PLAYERS; n++) begin
            c.coin[n]  = INV ^ (p[n][`BOARD_COIN_BIT] | k.coin[n]);
            c.start[n] = INV ^ (p[n][`BOARD_START_BIT] | k.start[n]);
        end
        c.service = INV ^ k.service;
        return c;
    endfunction

    function automatic dip_cfg_t expect_dip(input logic [31:0] s, input logic paused);
        dip_cfg_t d;
        d.rot_control = s[`BOARD_ST_ROT];
        d.flip        = s[`BOARD_ST_FLIP];
        d.test        = s[`BOARD_ST_TEST];
        d.enable_fm   = !s[`BOARD_ST_NO_FM];
        d.enable_psg  = !s[`BOARD_ST_NO_PSG];
        d.fxlevel     = {s[`BOARD_ST_FX_LSB+1], s[`BOARD_ST_FX_LSB]};
        d.pause       = !paused;
        return d;
    endfunction

    // fills stimulus row by row and tracks the pause and gfx toggles
    task automatic build_table();
        row_t        row;
        logic [63:0] rnd;
        logic        paused;
        logic        pp;
        logic        last_kp;
        logic        last_pp;
        logic [3:0]  gfx;
        logic [3:0]  last_gfx;
        paused   = 1'b0;
        last_kp  = 1'b0;
        last_pp  = 1'b0;
        gfx      = 4'hf;
        last_gfx = 4'h0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = '0;
            case (r)
                1, 2, 3, 4: begin
                    row.status                     = $urandom;
                    row.status[`BOARD_ST_ROT]      = (r > 2);
                    rnd                            = {$urandom, $urandom};
                    row.keys                       = rnd[$bits(key_map_t)-1:0];
                    row.keys.pause                 = 1'b0;
                    row.pads                       = {$urandom, $urandom};
                    row.pads[0][`BOARD_PAUSE_BIT]  = 1'b0;   // pause has its own rows
                    row.pads[1][`BOARD_PAUSE_BIT]  = 1'b0;
                end
                5, 6: row.keys.pause = 1'b1;             // second row only holds it
                7, 8: row.pads[1][`BOARD_PAUSE_BIT] = 1'b1;
                9, 10, 11, 12: row.keys.gfx = 4'b0001 << (r - 9);
                13: row.status = 32'h0001_6c04;
                14: row.status = 32'h0000_8000;
                default: row = '0;
            endcase
            pp = row.pads[0][`BOARD_PAUSE_BIT] | row.pads[1][`BOARD_PAUSE_BIT];
            if ((row.keys.pause && !last_kp) || (pp && !last_pp)) begin
                paused = !paused;
            end
            gfx      = gfx ^ (row.keys.gfx & ~last_gfx);
            last_kp  = row.keys.pause;
            last_pp  = pp;
            last_gfx = row.keys.gfx;
            row.exp_ctrl = expect_ctrl(row.keys, row.pads, row.status[`BOARD_ST_ROT]);
            row.exp_dip  = expect_dip(row.status, paused);
            row.exp_gfx  = gfx;
            tbl[r] = row;
        end
    endtask

    task automatic check_reset_release();
        int n;
        repeat (5) @(posedge clk_sys);
        rst <= 1'b0;
        n = 0;
        do begin
            @(posedge clk_sys);
            n++;
            #1;
        end while (sys_rst && n < 40);
        check("sys_rst release edges", n, 16);
        n = 0;
        do begin
            @(posedge clk_sys);
            n++;
            #1;
        end while (!sys_rst_n && n < 10);
        check("sys_rst_n release edges", n, 2);   // game_rst keeps counting meanwhile
        do begin
            @(posedge clk_sys);
            n++;
            #1;
        end while (game_rst && n < 40);
        check("game_rst release edges", n, 16);
        check("gfx_en", gfx_en, 4'hf);
        check("game_ctrl.service", game_ctrl.service, INV);
    endtask

    task automatic apply_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk_sys);
            status <= tbl[r].status;
            keys   <= tbl[r].keys;
            pads   <= tbl[r].pads;
            repeat (HOLD_EDGES) @(posedge clk_sys);
            @(negedge clk_sys);
            check($sformatf("row %0d game_ctrl", r), game_ctrl, tbl[r].exp_ctrl);
            check($sformatf("row %0d dip_cfg", r), dip_cfg, tbl[r].exp_dip);
            check($sformatf("row %0d gfx_en", r), gfx_en, tbl[r].exp_gfx);
        end
    endtask

    // kind 0 key reset, 1 rst_req, 2 flip change, 3 downloading
    task automatic fire_trigger(input int kind, input int exp_edges, input string name);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        @(posedge clk_sys);
        case (kind)
            0:       keys.reset <= 1'b1;
            1:       rst_req <= 1'b1;
            2:       status[`BOARD_ST_FLIP] <= ~status[`BOARD_ST_FLIP];
            default: downloading <= 1'b1;
        endcase
        @(posedge clk_sys);
        keys.reset  <= 1'b0;
        rst_req     <= 1'b0;
        downloading <= 1'b0;
        do begin
            @(posedge clk_sys);
            n++;
            #1;
            seen = seen | game_rst;
        end while ((game_rst || !seen) && n < 40);
        check({name, " raised game_rst"}, seen, 1'b1);
        check({name, " game_rst edges"}, n, exp_edges);
        n = 0;
        do begin
            @(posedge clk_sys);
            n++;
            #1;
        end while (!game_rst_n && n < 10);
        check({name, " game_rst_n edges"}, n, 2);
    endtask

    initial begin
        int assert_fails;
        void'($urandom(65));
        rst         = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        status      = '0;
        keys        = '0;
        pads        = '0;
        build_table();
        check_reset_release();
        apply_table();
        repeat (24) @(posedge clk_sys);   // let the last flip stretch run out
        fire_trigger(0, 17, "key reset");  // soft_rst adds an edge
        fire_trigger(1, 16, "rst_req");
        fire_trigger(2, 17, "flip change");
        fire_trigger(3, 16, "downloading");
        assert_fails = u_board_top.u_assertions.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hw
hw/board_pkg.sv
hw/board_reset.sv
hw/board_inputs.sv
hw/board_dip.sv
hw/board_top.sv
dv/board_assertions.sv
dv/board_tb.sv

/* hw/board_dip.sv */
// board_dip: registered decode of the osd status word and pause state
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module board_dip (
    input  logic                clk_sys,
    input  logic [31:0]         status,
    input  logic                game_pause,
    output board_pkg::dip_cfg_t dip_cfg
);

    import board_pkg::*;

    dip_cfg_t cfg_d;

    always_comb begin
        cfg_d.rot_control = status[`BOARD_ST_ROT];
        cfg_d.flip        = status[`BOARD_ST_FLIP];
        cfg_d.test        = status[`BOARD_ST_TEST];

        // status holds disable bits for the sound chips
        cfg_d.enable_fm   = ~status[`BOARD_ST_NO_FM];
        cfg_d.enable_psg  = ~status[`BOARD_ST_NO_PSG];

        cfg_d.fxlevel     = status[`BOARD_ST_FX_LSB +: 2];
        cfg_d.pause       = ~game_pause;   // game expects low while paused
    end

    // one register stage
    always_ff @(posedge clk_sys) begin
        dip_cfg <= cfg_d;
    end

endmodule

`default_nettype wire

/* hw/board_inputs.sv */
// board_inputs: pad sync, key merge, rotation, inversion, pause/gfx toggles and soft reset
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module board_inputs (
    input  logic                  clk_sys,
    input  logic                  sys_rst,
    input  logic                  rot_control,
    input  board_pkg::pads_t      pads,
    input  board_pkg::key_map_t   keys,
    output board_pkg::game_ctrl_t game_ctrl,
    output logic [3:0]            gfx_en,
    output logic                  game_pause,
    output logic                  soft_rst
);

    import board_pkg::*;

    localparam logic INV = 1'(`BOARD_INPUTS_ACTIVE_LOW);

    pads_t                     pads_q;        // single sync stage
    logic [`BOARD_PLAYERS-1:0] pad_coin;
    logic [`BOARD_PLAYERS-1:0] pad_start;
    logic                      joy_pause;
    logic                      last_key_pause;
    logic                      last_joy_pause;
    logic                      last_key_reset;
    logic [3:0]                last_gfx;
    game_joy_t                 joy1_mix;
    game_joy_t                 joy2_mix;

    // quarter turn of the directions, buttons untouched, then polarity
    function automatic game_joy_t map_joy(input game_joy_t joy, input logic rot);
        game_joy_t res;
        res = joy;
        if (rot) begin
            res.dirs = {joy.dirs[0], joy.dirs[1], joy.dirs[3], joy.dirs[2]};
        end
        res = res ^ {`BOARD_JOY_W{INV}};
        return res;
    endfunction

    always_comb begin
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            pad_coin[p]  = pads_q[p][`BOARD_COIN_BIT];
            pad_start[p] = pads_q[p][`BOARD_START_BIT];
        end
    end

    assign joy_pause = pads_q[0][`BOARD_PAUSE_BIT] | pads_q[1][`BOARD_PAUSE_BIT];

    // keyboard only drives players 1 and 2
    assign joy1_mix = pads_q[0][`BOARD_JOY_W-1:0] | keys.joy1;
    assign joy2_mix = pads_q[1][`BOARD_JOY_W-1:0] | keys.joy2;

    always_ff @(posedge clk_sys) begin
        pads_q         <= pads;
        last_key_pause <= keys.pause;
        last_joy_pause <= joy_pause;
        last_key_reset <= keys.reset;
        last_gfx       <= keys.gfx;

        game_ctrl.joystick1 <= map_joy(joy1_mix, rot_control);
        game_ctrl.joystick2 <= map_joy(joy2_mix, rot_control);
        game_ctrl.joystick3 <= pads_q[2][`BOARD_JOY_W-1:0] ^ {`BOARD_JOY_W{INV}};  // no rotation
        game_ctrl.joystick4 <= pads_q[3][`BOARD_JOY_W-1:0] ^ {`BOARD_JOY_W{INV}};
        game_ctrl.coin      <= {`BOARD_PLAYERS{INV}} ^ (pad_coin | keys.coin);
        game_ctrl.start     <= {`BOARD_PLAYERS{INV}} ^ (pad_start | keys.start);

        if (sys_rst) begin
            game_ctrl.service <= INV;
            game_pause        <= 1'b0;
            soft_rst          <= 1'b0;
            gfx_en            <= 4'hf;   // all layers on
        end else begin
            game_ctrl.service <= keys.service ^ INV;
            soft_rst          <= keys.reset & ~last_key_reset;

            // either source toggles, holding it does nothing more
            if ((keys.pause & ~last_key_pause) | (joy_pause & ~last_joy_pause)) begin
                game_pause <= ~game_pause;
            end

            for (int g = 0; g < 4; g++) begin
                if (keys.gfx[g] & ~last_gfx[g]) begin
                    gfx_en[g] <= ~gfx_en[g];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/board_params.svh */
// widths, counts, pad bit positions, status bit positions and input polarity for the board glue
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// pads and joysticks
`define BOARD_PLAYERS           4
`define BOARD_PAD_W             16
`define BOARD_JOY_W             10
`define BOARD_BUTTONS           2     // buttons the game actually uses

// extra pad bits shift up with the button count
`define BOARD_START_BIT         (6 + `BOARD_BUTTONS - 2)
`define BOARD_COIN_BIT          (7 + `BOARD_BUTTONS - 2)
`define BOARD_PAUSE_BIT         (8 + `BOARD_BUTTONS - 2)

`define BOARD_RST_CNT_W         4     // reset stretch length is 2**W edges
`define BOARD_INPUTS_ACTIVE_LOW 1     // game sees inverted inputs

// osd status word
`define BOARD_ST_ROT            2
`define BOARD_ST_FLIP           10
`define BOARD_ST_TEST           11
`define BOARD_ST_NO_FM          13
`define BOARD_ST_NO_PSG         14
`define BOARD_ST_FX_LSB         15    // two bits wide

`endif

/* hw/board_pkg.sv */
// board_pkg with pad, key map, game control and dip setting types
`default_nettype none

`include "board_params.svh"

package board_pkg;

    typedef logic [`BOARD_PAD_W-1:0] pad_t;    // raw pad word from the framework
    typedef pad_t [`BOARD_PLAYERS-1:0] pads_t;

    typedef struct packed {
        logic [`BOARD_JOY_W-5:0] buttons;
        logic [3:0]              dirs;           // up/down/left/right order of the pad
    } game_joy_t;

    // keyboard after decoding
    typedef struct packed {
        game_joy_t                joy1;
        game_joy_t                joy2;
        logic [`BOARD_PLAYERS-1:0] start;
        logic [`BOARD_PLAYERS-1:0] coin;
        logic                     reset;
        logic                     pause;
        logic                     service;
        logic [3:0]               gfx;           // one per graphics layer
    } key_map_t;

    typedef struct packed {
        game_joy_t                joystick1;
        game_joy_t                joystick2;
        game_joy_t                joystick3;
        game_joy_t                joystick4;
        logic [`BOARD_PLAYERS-1:0] coin;
        logic [`BOARD_PLAYERS-1:0] start;
        logic                     service;
    } game_ctrl_t;

    typedef struct packed {
        logic       rot_control;
        logic       flip;
        logic       test;
        logic       enable_fm;
        logic       enable_psg;
        logic [1:0] fxlevel;
        logic       pause;       // active low
    } dip_cfg_t;

endpackage

`default_nettype wire

/* hw/board_reset.sv */
// board_reset: system and game reset stretchers with active-low deassert chains
`timescale 1ns/1ps
`default_nettype none

`include "board_params.svh"

module board_reset (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic soft_rst,
    input  logic flip,
    output logic sys_rst,
    output logic sys_rst_n,
    output logic game_rst,
    output logic game_rst_n
);

    localparam int CW = `BOARD_RST_CNT_W;
    localparam logic [CW-1:0] CNT_MAX = '1;

    // index 0 is the system reset, index 1 the game reset
    logic              flip_q;
    logic [1:0]        trig;
    logic [1:0][CW-1:0] cnt;
    logic [1:0]        stretch;
    logic [1:0]        assert_src;
    logic [1:0]        pre_n;
    logic [1:0]        rst_n_q;

    always_ff @(posedge clk_sys) begin
        flip_q <= flip;  // a screen flip restarts the game
    end

    assign trig[0] = rst;
    assign trig[1] = sys_rst | downloading | rst_req | soft_rst | (flip ^ flip_q);

    // both counters restart on their trigger and saturate at CNT_MAX,
    // so the output drops on the 16th edge after the last trigger
    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < 2; i++) begin
            if (trig[i]) begin
                cnt[i]     <= '0;
                stretch[i] <= 1'b1;
            end else if (cnt[i] != CNT_MAX) begin
                cnt[i]     <= cnt[i] + 1'b1;
                stretch[i] <= 1'b1;
            end else begin
                stretch[i] <= 1'b0;  // saturated
            end
        end
    end

    assign sys_rst  = stretch[0];
    assign game_rst = stretch[1];

    assign assert_src = {game_rst, sys_rst | downloading};

    // asserts one edge after the source, releases two edges after it clears
    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < 2; i++) begin
            if (assert_src[i]) begin
                pre_n[i]   <= 1'b0;
                rst_n_q[i] <= 1'b0;
            end else begin
                pre_n[i]   <= 1'b1;
                rst_n_q[i] <= pre_n[i];
            end
        end
    end

    assign sys_rst_n  = rst_n_q[0];
    assign game_rst_n = rst_n_q[1];

endmodule

`default_nettype wire

/* hw/board_top.sv */
// board_top: reset generation, input mapping and dip decode for the clk_sys domain
`timescale 1ns/1ps
`default_nettype none

module board_top (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  rst_req,
    input  logic                  downloading,
    input  logic [31:0]           status,
    input  board_pkg::key_map_t   keys,      // already in clk_sys
    input  board_pkg::pads_t      pads,      // asynchronous
    output logic                  sys_rst,
    output logic                  sys_rst_n,
    output logic                  game_rst,
    output logic                  game_rst_n,
    output board_pkg::game_ctrl_t game_ctrl,
    output logic [3:0]            gfx_en,
    output board_pkg::dip_cfg_t   dip_cfg
);

    logic game_pause;
    logic soft_rst;    // one cycle pulse from the reset key

    board_reset u_reset (
        .clk_sys     ( clk_sys       ),
        .rst         ( rst           ),
        .downloading ( downloading   ),
        .rst_req     ( rst_req       ),
        .soft_rst    ( soft_rst      ),
        .flip        ( dip_cfg.flip  ),  // flip change restarts the game
        .sys_rst     ( sys_rst       ),
        .sys_rst_n   ( sys_rst_n     ),
        .game_rst    ( game_rst      ),
        .game_rst_n  ( game_rst_n    )
    );

    board_inputs u_inputs (
        .clk_sys     ( clk_sys             ),
        .sys_rst     ( sys_rst             ),
        .rot_control ( dip_cfg.rot_control ),
        .pads        ( pads                ),
        .keys        ( keys                ),
        .game_ctrl   ( game_ctrl           ),
        .gfx_en      ( gfx_en              ),
        .game_pause  ( game_pause          ),
        .soft_rst    ( soft_rst            )
    );

    board_dip u_dip (
        .clk_sys     ( clk_sys    ),
        .status      ( status     ),
        .game_pause  ( game_pause ),
        .dip_cfg     ( dip_cfg    )
    );

endmodule

`default_nettype wire
